/* common/loader_pkg.sv */
package loader_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  key_t;

    // Sequencer states, also visible on fsm_state_o
    typedef enum logic [2:0] {
        ENTRY,
        STORE,
        COUNT,
        RUN,
        SHOW_REQ,
        SHOW_WAIT,
        SHOW_HOLD,
        DONE
    } seq_state_t;

    // Keypad codes (ASCII)
    localparam key_t KEY_STORE  = 8'h2a;
    localparam key_t KEY_COMMIT = 8'h23;
    localparam key_t KEY_STOP   = 8'h44;
    localparam key_t KEY_ZERO   = 8'h30;

    // Processor halt word
    localparam word_t HALT_INSTR = 32'h6000_2023;

    // Entered keys from word 0 upward, entry count in the last word
    localparam addr_t DATA_BASE = 32'h0000_0000;
    localparam addr_t COUNT_ADR = 32'h0000_00fc;

    // Access wait of the request unit
    localparam int MEM_WAIT = 3;
    localparam int WAIT_W   = $clog2(MEM_WAIT + 1);

    localparam int RAM_WORDS = 64;
    localparam int RAM_AW    = 6;

endpackage

/* dv/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Compare helpers, one per kind of DUT result

task automatic check_key(
    input string name,
    input key_t  exp,
    input key_t  act
);
    if (act !== exp) begin
        report_failure($sformatf("MISMATCH at %0t ns: %s expected 8'h%02h, got 8'h%02h",
                                 $time, name, exp, act));
    end
endtask

task automatic check_state(
    input string      name,
    input seq_state_t exp,
    input seq_state_t act
);
    if (act !== exp) begin
        report_failure($sformatf("MISMATCH at %0t ns: %s expected %s, got %s",
                                 $time, name, exp.name(), act.name()));
    end
endtask

task automatic check_bit(
    input string name,
    input logic  exp,
    input logic  act
);
    if (act !== exp) begin
        report_failure($sformatf("MISMATCH at %0t ns: %s expected %0b, got %0b",
                                 $time, name, exp, act));
    end
endtask

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

/* dv/tb_keypad_loader.sv */
`timescale 1ns/10ps

module tb_keypad_loader;
    import loader_pkg::*;

    localparam int          NUM_TESTS       = 5;
    localparam int          CYCLES_PER_TEST = 2000;
    localparam logic [31:0] RNG_SEED        = 32'hec3a_e586;
    // Character the LCD gets for an empty word
    localparam key_t        SHOW_ZERO       = 8'h30;

    logic       clk;
    logic       nRST;
    key_t       data;
    logic       keyvalid;
    word_t      instruction;
    logic       pc_enable;
    key_t       display;
    logic       lcd_en;
    seq_state_t fsm_state;

    logic [31:0] rng;
    key_t        expected[$];

    keypad_loader_top u_keypad_loader_top (
        .clk           (clk),
        .nRST          (nRST),
        .data_i        (data),
        .keyvalid_i    (keyvalid),
        .instruction_i (instruction),
        .pc_enable_o   (pc_enable),
        .display_o     (display),
        .lcd_en_o      (lcd_en),
        .fsm_state_o   (fsm_state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    `include "tb_checks.svh"

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Random digit or capital letter
    function automatic key_t pick_key();
        logic [31:0] r;
        r = next_rand() % 36;
        if (r < 10) begin
            return 8'h30 + r[7:0];
        end
        return 8'h41 + r[7:0] - 8'd10;
    endfunction

    function automatic logic accepting(input seq_state_t s);
        return (s == ENTRY) || (s == RUN) || (s == SHOW_HOLD) || (s == DONE);
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        nRST        <= 1'b0;
        keyvalid    <= 1'b0;
        data        <= '0;
        instruction <= '0;
        repeat (5) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);
    endtask

    // One-cycle strobe, returns once the DUT has seen it
    task automatic strobe(input key_t k);
        @(posedge clk);
        data     <= k;
        keyvalid <= 1'b1;
        @(posedge clk);
        keyvalid <= 1'b0;
        data     <= '0;
        @(negedge clk);
    endtask

    task automatic press(input key_t k);
        strobe(k);
        while (!accepting(fsm_state)) @(negedge clk);
    endtask

    task automatic wait_show();
        while (!lcd_en && fsm_state != SHOW_HOLD && fsm_state != DONE) @(negedge clk);
    endtask

    task automatic load_entries(input int n);
        key_t k;
        expected.delete();
        for (int i = 0; i < n; i++) begin
            if (next_rand() % 4 == 0) begin
                // Bare * stores an empty word
                expected.push_back(SHOW_ZERO);
            end else begin
                k = pick_key();
                press(k);
                check_key("display_o", k, display);
                expected.push_back(k);
            end
            press(KEY_STORE);
            check_state("fsm_state_o", ENTRY, fsm_state);
            check_key("display_o", 8'h00, display);
        end
        press(KEY_COMMIT);
        check_state("fsm_state_o", RUN, fsm_state);
        check_bit("pc_enable_o", 1'b1, pc_enable);
    endtask

    task automatic end_run(input logic use_stop);
        if (use_stop) begin
            strobe(KEY_STOP);
        end else begin
            @(posedge clk);
            instruction <= HALT_INSTR;
            @(negedge clk);
            while (fsm_state == RUN) @(negedge clk);
        end
        check_state("fsm_state_o", SHOW_REQ, fsm_state);
        check_bit("pc_enable_o", 1'b0, pc_enable);
        if (!use_stop) begin
            @(posedge clk);
            instruction <= '0;
        end
    endtask

    task automatic check_pulse(input key_t exp);
        wait_show();
        check_bit("lcd_en_o", 1'b1, lcd_en);
        check_state("fsm_state_o", SHOW_HOLD, fsm_state);
        check_key("display_o", exp, display);
        @(negedge clk);
        check_bit("lcd_en_o", 1'b0, lcd_en);
    endtask

    task automatic playback(input int n);
        for (int i = 0; i < n; i++) begin
            if (i != 0) begin
                strobe(KEY_COMMIT);
                check_key("display_o", 8'h00, display);
            end
            check_pulse(expected[i]);
        end
        strobe(KEY_COMMIT);
        wait_show();
        check_state("fsm_state_o", DONE, fsm_state);
        check_bit("lcd_en_o", 1'b0, lcd_en);
    endtask

    task automatic test_reset_values();
        check_bit("pc_enable_o", 1'b0, pc_enable);
        check_bit("lcd_en_o", 1'b0, lcd_en);
        check_key("display_o", 8'h00, display);
        check_state("fsm_state_o", ENTRY, fsm_state);
    endtask

    task automatic test_key_echo();
        key_t k;
        repeat (2) begin
            k = pick_key();
            strobe(k);
            check_key("display_o", k, display);
            check_state("fsm_state_o", ENTRY, fsm_state);
        end
    endtask

    task automatic test_load_and_play(input logic use_stop);
        int n;
        apply_reset();
        n = 1 + int'(next_rand() % 8);
        load_entries(n);
        // No end condition yet, processor keeps running
        repeat (3) @(negedge clk);
        check_state("fsm_state_o", RUN, fsm_state);
        check_bit("pc_enable_o", 1'b1, pc_enable);
        end_run(use_stop);
        playback(n);
    endtask

    task automatic test_abort();
        int n;
        apply_reset();
        n = 2 + int'(next_rand() % 7);
        load_entries(n);
        end_run(1'b0);
        check_pulse(expected[0]);
        strobe(KEY_STORE);
        check_state("fsm_state_o", SHOW_HOLD, fsm_state);
        strobe(KEY_COMMIT);
        check_state("fsm_state_o", SHOW_REQ, fsm_state);
        wait_show();
        check_state("fsm_state_o", DONE, fsm_state);
        repeat (10) begin
            @(negedge clk);
            check_bit("lcd_en_o", 1'b0, lcd_en);
            check_state("fsm_state_o", DONE, fsm_state);
        end
        check_key("display_o", 8'h00, display);
    endtask

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        report_failure($sformatf("Timeout: tests did not finish within %0d cycles",
                                 NUM_TESTS * CYCLES_PER_TEST));
    end

    initial begin
        nRST        = 1'b0;
        keyvalid    = 1'b0;
        data        = '0;
        instruction = '0;
        rng         = RNG_SEED;
        apply_reset();
        test_reset_values();
        test_key_echo();
        test_load_and_play(1'b0);
        test_load_and_play(1'b1);
        test_abort();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* rtl/data_ram.sv */
`timescale 1ns/10ps

module data_ram (
    input  logic                          clk,
    input  logic                          we_i,
    input  logic [loader_pkg::RAM_AW-1:0] idx_i,
    input  loader_pkg::word_t             wdata_i,
    output loader_pkg::word_t             rdata_o
);
    import loader_pkg::*;

    word_t mem [RAM_WORDS];

    // Read returns the old word when written in the same cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[idx_i] <= wdata_i;
        end
        rdata_o <= mem[idx_i];
    end

endmodule

/* rtl/key_sequencer/key_sequencer.sv */
`timescale 1ns/10ps

module key_sequencer (
    input  logic                   clk,
    input  logic                   nRST,
    // Keypad
    input  loader_pkg::key_t       data_i,
    input  logic                   keyvalid_i,
    // Processor
    input  loader_pkg::word_t      instruction_i,
    // Request unit
    input  logic                   done_i,
    input  loader_pkg::word_t      rd_data_i,
    output logic                   write_req_o,
    output logic                   read_req_o,
    output loader_pkg::addr_t      req_adr_o,
    output loader_pkg::word_t      req_wdata_o,
    // Board side
    output logic                   pc_enable_o,
    output loader_pkg::key_t       display_o,
    output logic                   lcd_en_o,
    output loader_pkg::seq_state_t fsm_state_o
);
    import loader_pkg::*;

    seq_state_t state;
    seq_state_t next_state;

    word_t idx;
    word_t next_idx;
    word_t count;
    word_t next_count;
    logic  stop_pend;
    logic  next_stop_pend;

    logic  next_write_req;
    logic  next_read_req;
    addr_t next_adr;
    word_t next_wdata;
    logic  next_pc_enable;
    key_t  next_display;
    logic  next_lcd_en;

    logic  key_store;
    logic  key_commit;
    logic  key_stop;
    logic  halt_seen;

    assign key_store  = keyvalid_i && (data_i == KEY_STORE);
    assign key_commit = keyvalid_i && (data_i == KEY_COMMIT);
    assign key_stop   = keyvalid_i && (data_i == KEY_STOP);
    assign halt_seen  = (instruction_i == HALT_INSTR);

    assign fsm_state_o = state;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state       <= ENTRY;
            idx         <= '0;
            count       <= '0;
            stop_pend   <= 1'b0;
            write_req_o <= 1'b0;
            read_req_o  <= 1'b0;
            req_adr_o   <= '0;
            req_wdata_o <= '0;
            pc_enable_o <= 1'b0;
            display_o   <= '0;
            lcd_en_o    <= 1'b0;
        end else begin
            state       <= next_state;
            idx         <= next_idx;
            count       <= next_count;
            stop_pend   <= next_stop_pend;
            write_req_o <= next_write_req;
            read_req_o  <= next_read_req;
            req_adr_o   <= next_adr;
            req_wdata_o <= next_wdata;
            pc_enable_o <= next_pc_enable;
            display_o   <= next_display;
            lcd_en_o    <= next_lcd_en;
        end
    end

    always_comb begin
        next_state     = state;
        next_idx       = idx;
        next_count     = count;
        next_stop_pend = stop_pend;
        next_write_req = 1'b0;
        next_read_req  = 1'b0;
        next_adr       = req_adr_o;
        next_wdata     = req_wdata_o;
        next_pc_enable = pc_enable_o;
        next_display   = display_o;
        next_lcd_en    = 1'b0;

        case (state)
            ENTRY: begin
                if (key_store) begin
                    next_write_req = 1'b1;
                    next_adr       = DATA_BASE + (idx << 2);
                    next_state     = STORE;
                end else if (key_commit) begin
                    next_write_req = 1'b1;
                    next_adr       = COUNT_ADR;
                    next_wdata     = idx;
                    next_count     = idx;
                    next_state     = COUNT;
                end else if (keyvalid_i) begin
                    // Echo the key and keep it as the pending word
                    next_display = data_i;
                    next_wdata   = {24'b0, data_i};
                end
            end

            STORE: begin
                if (done_i) begin
                    next_idx     = idx + 1'b1;
                    next_display = '0;
                    // A * with no key in front stores zero
                    next_wdata   = '0;
                    next_state   = ENTRY;
                end
            end

            COUNT: begin
                if (done_i) begin
                    next_idx       = '0;
                    next_wdata     = '0;
                    next_pc_enable = 1'b1;
                    next_state     = RUN;
                end
            end

            RUN: begin
                // Processor memory traffic is not tracked here
                if (halt_seen || key_stop) begin
                    next_pc_enable = 1'b0;
                    next_idx       = '0;
                    next_stop_pend = 1'b0;
                    next_state     = SHOW_REQ;
                end
            end

            SHOW_REQ: begin
                if (key_store || stop_pend || (idx == count)) begin
                    next_stop_pend = 1'b0;
                    next_state     = DONE;
                end else begin
                    next_read_req = 1'b1;
                    next_adr      = DATA_BASE + (idx << 2);
                    next_state    = SHOW_WAIT;
                end
            end

            SHOW_WAIT: begin
                // Read request stays up until the unit answers
                next_read_req = 1'b1;
                if (done_i) begin
                    next_read_req = 1'b0;
                    next_idx      = idx + 1'b1;
                    next_lcd_en   = 1'b1;
                    next_display  = (rd_data_i[7:0] == 8'h00) ? KEY_ZERO : rd_data_i[7:0];
                    next_state    = SHOW_HOLD;
                end
            end

            SHOW_HOLD: begin
                if (key_store) begin
                    next_stop_pend = 1'b1;
                end
                if (key_commit) begin
                    next_display = '0;
                    next_state   = SHOW_REQ;
                end
            end

            DONE: begin
                // Held until the next reset
            end

            default: begin
                next_state = ENTRY;
            end
        endcase
    end

    // Only one request kind toward the memory unit at a time
    a_req_exclusive: assert property (
        @(posedge clk) disable iff (!nRST)
        !(read_req_o && write_req_o)
    );

    // Processor runs only while the sequencer sits in RUN
    a_pc_enable_run: assert property (
        @(posedge clk) disable iff (!nRST)
        pc_enable_o |-> (state == RUN)
    );

endmodule

/* rtl/keypad_loader_top.sv */
`timescale 1ns/10ps

module keypad_loader_top (
    input  logic                   clk,
    input  logic                   nRST,
    input  loader_pkg::key_t       data_i,
    input  logic                   keyvalid_i,
    input  loader_pkg::word_t      instruction_i,
    output logic                   pc_enable_o,
    output loader_pkg::key_t       display_o,
    output logic                   lcd_en_o,
    output loader_pkg::seq_state_t fsm_state_o
);
    import loader_pkg::*;

    // Sequencer to request unit
    logic  write_req;
    logic  read_req;
    addr_t req_adr;
    word_t req_wdata;
    logic  done;
    word_t rd_data;

    // Request unit to RAM
    logic              ram_we;
    logic [RAM_AW-1:0] ram_idx;
    word_t             ram_wdata;
    word_t             ram_rdata;

    key_sequencer u_key_sequencer (
        .clk           (clk),
        .nRST          (nRST),
        .data_i        (data_i),
        .keyvalid_i    (keyvalid_i),
        .instruction_i (instruction_i),
        .done_i        (done),
        .rd_data_i     (rd_data),
        .write_req_o   (write_req),
        .read_req_o    (read_req),
        .req_adr_o     (req_adr),
        .req_wdata_o   (req_wdata),
        .pc_enable_o   (pc_enable_o),
        .display_o     (display_o),
        .lcd_en_o      (lcd_en_o),
        .fsm_state_o   (fsm_state_o)
    );

    mem_request u_mem_request (
        .clk         (clk),
        .nRST        (nRST),
        .write_req_i (write_req),
        .read_req_i  (read_req),
        .adr_i       (req_adr),
        .wdata_i     (req_wdata),
        .done_o      (done),
        .rd_data_o   (rd_data),
        .ram_we_o    (ram_we),
        .ram_idx_o   (ram_idx),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .idx_i   (ram_idx),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

/* rtl/mem_request.sv */
`timescale 1ns/10ps

module mem_request (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic                          write_req_i,
    input  logic                          read_req_i,
    input  loader_pkg::addr_t             adr_i,
    input  loader_pkg::word_t             wdata_i,
    output logic                          done_o,
    output loader_pkg::word_t             rd_data_o,
    output logic                          ram_we_o,
    output logic [loader_pkg::RAM_AW-1:0] ram_idx_o,
    output loader_pkg::word_t             ram_wdata_o,
    input  loader_pkg::word_t             ram_rdata_i
);
    import loader_pkg::*;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_WAIT,
        REQ_ACCESS
    } req_state_t;

    req_state_t        state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              is_write;
    logic [RAM_AW-1:0] idx_q;
    word_t             wdata_q;
    logic              accept;

    // The done cycle still counts as busy, a held read is not taken twice
    assign accept = (state == REQ_IDLE) && !done_o && (write_req_i || read_req_i);

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state    <= REQ_IDLE;
            wait_cnt <= '0;
            is_write <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                REQ_IDLE: begin
                    if (accept) begin
                        state    <= REQ_WAIT;
                        wait_cnt <= WAIT_W'(MEM_WAIT - 1);
                        is_write <= write_req_i;
                    end
                end
                REQ_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= REQ_ACCESS;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                REQ_ACCESS: begin
                    // Read data leaves the RAM register in the done cycle
                    state  <= REQ_IDLE;
                    done_o <= 1'b1;
                end
                default: begin
                    state <= REQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q   <= adr_i[RAM_AW+1:2];
            wdata_q <= wdata_i;
        end
    end

    assign ram_we_o    = (state == REQ_ACCESS) && is_write;
    assign ram_idx_o   = idx_q;
    assign ram_wdata_o = wdata_q;
    assign rd_data_o   = ram_rdata_i;

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!nRST)
        done_o |=> !done_o
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_keypad_loader -f sources.f -o sim

output=$(./obj_dir/sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
else
    exit 1
fi

/* sources.f */
+incdir+dv
common/loader_pkg.sv
rtl/data_ram.sv
rtl/mem_request.sv
rtl/key_sequencer/key_sequencer.sv
rtl/keypad_loader_top.sv
dv/tb_keypad_loader.sv
